//--- bp_fe_predict_top.f
bp_fe_pkg.sv
bp_fe_btb.sv
bp_fe_bht.sv
bp_fe_branch_predictor.sv
bp_fe_pc_gen.sv
bp_fe_predict_top.sv
bp_fe_predict_checker.sv
tb_bp_fe_predict_top.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the front end testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
   -f bp_fe_predict_top.f \
   --top-module tb_bp_fe_predict_top \
   -Mdir obj_dir

./obj_dir/Vtb_bp_fe_predict_top > sim.log 2>&1
cat sim.log

if grep -q "sim failed" sim.log; then
   exit 1
fi
exit 0

//--- tb_bp_fe_predict_top.sv
// front end prediction testbench
`timescale 1ns/1ns
`default_nettype none

module tb_bp_fe_predict_top
   import bp_fe_pkg::*;
();

   localparam int CLK_PERIOD = 10;
   localparam int RST_CYCLES = 3;
   localparam int SEQ_CYCLES = 40;
   localparam int DIR_RUN    = 20;
   localparam int DIR_CYCLES = 30;     // updates, redirect and run of one directed phase
   localparam int ROUNDS     = 3;
   localparam int RAND_UPD   = 24;
   localparam int RAND_RUN   = 150;
   localparam int WATCHDOG_CYCLES = RST_CYCLES + SEQ_CYCLES + 2 * DIR_CYCLES
                                    + ROUNDS * (RAND_UPD + 1 + RAND_RUN) + 50;
   localparam logic [EADDR_WIDTH-1:0] REGION = 32'h0000_1000;   // branches live here

   logic                                 clk = 1'b0;
   logic                                 rst_n;
   logic                                 fetch_ready;
   logic                                 fetch_v;
   logic [EADDR_WIDTH-1:0]               fetch_pc;
   logic                                 fetch_predict;
   logic [EADDR_WIDTH-1:0]               fetch_target;
   logic [BRANCH_METADATA_FWD_WIDTH-1:0] fetch_metadata;
   logic                                 redir_v;
   logic [EADDR_WIDTH-1:0]               redir_pc;
   logic                                 upd_v;
   logic                                 upd_taken;
   logic [EADDR_WIDTH-1:0]               upd_pc;
   logic [EADDR_WIDTH-1:0]               upd_target;
   logic [BRANCH_METADATA_FWD_WIDTH-1:0] upd_metadata;
   logic [31:0]                          lfsr_state = 32'h533e_f350;
   logic [31:0]                          rnd;
   logic [EADDR_WIDTH-1:0]               br_pc;
   logic [EADDR_WIDTH-1:0]               br_tgt;
   int                                   err_count;
   int                                   fetch_count;
   int                                   taken_count;
   int                                   tb_errors;

   always #(CLK_PERIOD / 2) clk = ~clk;

   bp_fe_predict_top DUT (
      .clk_i(clk), .rst_n_i(rst_n),
      .fetch_ready_i(fetch_ready), .fetch_v_o(fetch_v), .fetch_pc_o(fetch_pc),
      .fetch_predict_o(fetch_predict), .fetch_target_o(fetch_target),
      .fetch_metadata_o(fetch_metadata),
      .redir_v_i(redir_v), .redir_pc_i(redir_pc),
      .upd_v_i(upd_v), .upd_taken_i(upd_taken), .upd_pc_i(upd_pc),
      .upd_target_i(upd_target), .upd_metadata_i(upd_metadata)
   );

   bp_fe_predict_checker u_checker (
      .clk_i(clk), .rst_n_i(rst_n),
      .fetch_ready_i(fetch_ready), .fetch_v_i(fetch_v), .fetch_pc_i(fetch_pc),
      .fetch_predict_i(fetch_predict), .fetch_target_i(fetch_target),
      .fetch_metadata_i(fetch_metadata),
      .redir_v_i(redir_v), .redir_pc_i(redir_pc),
      .upd_v_i(upd_v), .upd_taken_i(upd_taken), .upd_pc_i(upd_pc),
      .upd_target_i(upd_target), .upd_metadata_i(upd_metadata),
      .err_count_o(err_count), .fetch_count_o(fetch_count), .taken_count_o(taken_count)
   );

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // stimulus helpers
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic next_cycle();
      @(posedge clk);
      #1;                                      // drive away from the edge
   endtask

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32+x^22+x^2+x+1
   endfunction

   task automatic take_bits(input int n, output logic [31:0] val);
      val = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         val        = {val[30:0], lfsr_state[0]};
      end
   endtask

   task automatic pick_pc(output logic [EADDR_WIDTH-1:0] pc);
      logic [31:0] r;
      take_bits(8, r);
      pc = REGION + {r[29:0], 2'b00};
   endtask

   // 16 branch slots 16 words apart that share 4 BTB entries
   task automatic pick_branch_pc(output logic [EADDR_WIDTH-1:0] pc);
      logic [31:0] r;
      take_bits(4, r);
      pc = REGION + {r[25:0], 6'b000000};
   endtask

   // metadata as the back end would return it for the branch at pc
   function automatic logic [BRANCH_METADATA_FWD_WIDTH-1:0] meta_of(input logic [31:0] pc);
      return {pc[7:2], pc[9:2], 4'b0000};
   endfunction

   task automatic apply_update(input logic [31:0] pc, input logic [31:0] tgt,
                               input logic taken);
      fetch_ready  = 1'b0;                     // train only while stalled
      upd_v        = 1'b1;
      upd_pc       = pc;
      upd_target   = tgt;
      upd_taken    = taken;
      upd_metadata = meta_of(pc);
      next_cycle();
      upd_v = 1'b0;
   endtask

   task automatic redirect_to(input logic [31:0] pc);
      redir_v  = 1'b1;
      redir_pc = pc;
      next_cycle();
      redir_v = 1'b0;
   endtask

   task automatic run_stream(input int n, input logic gaps);
      logic [31:0] r;
      for (int i = 0; i < n; i++) begin
         fetch_ready = 1'b1;
         if (gaps) begin
            take_bits(2, r);
            fetch_ready = (r[1:0] != 2'b00);
            take_bits(5, r);
            if (r[4:0] == 5'd0) begin
               redir_v = 1'b1;                 // occasional redirect mid-stream
               pick_pc(redir_pc);
            end
         end
         next_cycle();
         redir_v = 1'b0;
      end
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // test sequence
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   initial begin
      rst_n        = 1'b0;
      fetch_ready  = 1'b0;
      redir_v      = 1'b0;
      redir_pc     = '0;
      upd_v        = 1'b0;
      upd_taken    = 1'b0;
      upd_pc       = '0;
      upd_target   = '0;
      upd_metadata = '0;
      tb_errors    = 0;
      repeat (RST_CYCLES) @(posedge clk);
      #1;
      rst_n = 1'b1;

      run_stream(SEQ_CYCLES, 1'b0);            // sequential fetch with empty tables

      apply_update(32'h0000_1040, 32'h0000_1200, 1'b1);
      apply_update(32'h0000_1040, 32'h0000_1200, 1'b1);
      redirect_to(32'h0000_1038);
      run_stream(DIR_RUN, 1'b0);

      // 1180 evicts 1080 from the shared BTB entry
      // 10a0 ends weakly not taken
      apply_update(32'h0000_1080, 32'h0000_1300, 1'b1);
      apply_update(32'h0000_1080, 32'h0000_1300, 1'b1);
      apply_update(32'h0000_1180, 32'h0000_1340, 1'b1);
      apply_update(32'h0000_1180, 32'h0000_1340, 1'b1);
      apply_update(32'h0000_10a0, 32'h0000_1380, 1'b1);
      apply_update(32'h0000_10a0, 32'h0000_1380, 1'b0);
      redirect_to(32'h0000_1078);
      run_stream(DIR_RUN, 1'b0);

      for (int k = 0; k < ROUNDS; k++) begin
         for (int j = 0; j < RAND_UPD; j++) begin
            pick_branch_pc(br_pc);
            pick_branch_pc(br_tgt);
            take_bits(2, rnd);
            apply_update(br_pc, br_tgt, rnd[1:0] != 2'b00);   // mostly taken
         end
         pick_branch_pc(br_pc);
         redirect_to(br_pc);
         run_stream(RAND_RUN, 1'b1);
      end

      fetch_ready = 1'b0;
      repeat (2) next_cycle();
      if (taken_count == 0) begin
         $display("no taken prediction was seen in the fetch stream");
         tb_errors++;
      end
      $display("errors %0d, fetches %0d, taken %0d",
               err_count + tb_errors, fetch_count, taken_count);
      if (err_count + tb_errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("watchdog expired before the test sequence finished");
      $display("sim failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- bp_fe_predict_checker.sv
// fetch stream checker
`timescale 1ns/1ns
`default_nettype none

module bp_fe_predict_checker
   import bp_fe_pkg::*;
(
   input  wire                                    clk_i,
   input  wire                                    rst_n_i,
   input  wire                                    fetch_ready_i,
   input  wire                                    fetch_v_i,
   input  wire [EADDR_WIDTH-1:0]                  fetch_pc_i,
   input  wire                                    fetch_predict_i,
   input  wire [EADDR_WIDTH-1:0]                  fetch_target_i,
   input  wire [BRANCH_METADATA_FWD_WIDTH-1:0]    fetch_metadata_i,
   input  wire                                    redir_v_i,
   input  wire [EADDR_WIDTH-1:0]                  redir_pc_i,
   input  wire                                    upd_v_i,
   input  wire                                    upd_taken_i,
   input  wire [EADDR_WIDTH-1:0]                  upd_pc_i,
   input  wire [EADDR_WIDTH-1:0]                  upd_target_i,
   input  wire [BRANCH_METADATA_FWD_WIDTH-1:0]    upd_metadata_i,
   output int                                     err_count_o,
   output int                                     fetch_count_o,
   output int                                     taken_count_o
);

   // model tables mirrored from the update port
   logic                     m_valid [BTB_ENTRIES];
   logic [BTB_TAG_WIDTH-1:0] m_tag   [BTB_ENTRIES];
   logic [EADDR_WIDTH-1:0]   m_tgt   [BTB_ENTRIES];
   logic [1:0]               m_ctr   [BHT_ENTRIES];

   logic [EADDR_WIDTH-1:0]               exp_pc;   // next pc the stream must show
   logic                                 exp_v;    // fetch valid as the pipeline timing gives it
   logic                                 e_pred;
   logic [EADDR_WIDTH-1:0]               e_tgt;
   logic [BRANCH_METADATA_FWD_WIDTH-1:0] e_meta;
   logic [BTB_IDX_WIDTH-1:0]             upd_bi;
   logic [BHT_IDX_WIDTH-1:0]             upd_hi;

   // all fetch outputs side by side for the stall hold check
   logic [EADDR_WIDTH*2+BRANCH_METADATA_FWD_WIDTH:0] cur_bus;
   logic [EADDR_WIDTH*2+BRANCH_METADATA_FWD_WIDTH:0] hold_bus;
   logic                                             hold_v;

   assign cur_bus = {fetch_pc_i, fetch_predict_i, fetch_target_i, fetch_metadata_i};

   task automatic report(input string what, input logic [EADDR_WIDTH-1:0] got,
                         input logic [EADDR_WIDTH-1:0] exp);
      $display("Fail %0t ns: %s is %h, expected %h", $time, what, got, exp);
      err_count_o++;
   endtask

   // prediction the tables should give for a lookup of pc
   function automatic void predict_for(input logic [EADDR_WIDTH-1:0] pc,
                                       output logic pred,
                                       output logic [EADDR_WIDTH-1:0] tgt,
                                       output logic [BRANCH_METADATA_FWD_WIDTH-1:0] meta);
      logic [BTB_IDX_WIDTH-1:0] bi;
      logic [BHT_IDX_WIDTH-1:0] hi;
      bi   = pc[2 +: BTB_IDX_WIDTH];
      hi   = pc[2 +: BHT_IDX_WIDTH];
      pred = m_valid[bi] && (m_tag[bi] == pc[EADDR_WIDTH-1 -: BTB_TAG_WIDTH]) && m_ctr[hi][1];
      tgt  = m_tgt[bi];
      meta = {bi, hi, {RAS_ADDR_WIDTH{1'b0}}};
   endfunction

   always @(posedge clk_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < BTB_ENTRIES; i++) begin
            m_valid[i] = 1'b0;
         end
         for (int i = 0; i < BHT_ENTRIES; i++) begin
            m_ctr[i] = 2'b01;                         // weakly not taken
         end
         exp_pc        = RESET_PC;
         exp_v         = 1'b0;
         hold_v        = 1'b0;
         err_count_o   = 0;
         fetch_count_o = 0;
         taken_count_o = 0;
      end else begin
         if (hold_v && (!fetch_v_i || cur_bus !== hold_bus)) begin
            $display("Fail %0t ns: fetch outputs changed while stalled", $time);
            err_count_o++;
         end
         if (fetch_v_i !== exp_v) begin
            report("fetch valid", 32'(fetch_v_i), 32'(exp_v));
         end
         hold_v   = fetch_v_i && !fetch_ready_i && !redir_v_i;
         hold_bus = cur_bus;
         // a redirect on the same edge flushes the item instead
         if (fetch_v_i && fetch_ready_i && !redir_v_i) begin
            predict_for(fetch_pc_i, e_pred, e_tgt, e_meta);
            fetch_count_o++;
            if (fetch_pc_i !== exp_pc) report("fetch pc", fetch_pc_i, exp_pc);
            if (fetch_predict_i !== e_pred) begin
               report("predict", 32'(fetch_predict_i), 32'(e_pred));
            end else if (e_pred && fetch_target_i !== e_tgt) begin
               report("target", fetch_target_i, e_tgt);
            end
            if (fetch_metadata_i !== e_meta) begin
               report("metadata", 32'(fetch_metadata_i), 32'(e_meta));
            end
            if (e_pred) taken_count_o++;
            exp_pc = e_pred ? e_tgt : fetch_pc_i + INSTR_BYTES;
         end
         if (redir_v_i) begin
            exp_pc = redir_pc_i;
            exp_v  = 1'b0;                            // s1 flushed
         end else if (fetch_ready_i) begin
            // a taken transfer squashes the sequential item behind it
            exp_v = !(fetch_v_i && e_pred);
         end
         // training comes after the read so a same-edge lookup sees old state
         if (upd_v_i) begin
            upd_bi = upd_metadata_i[META_BTB_LSB +: BTB_IDX_WIDTH];
            upd_hi = upd_metadata_i[META_BHT_LSB +: BHT_IDX_WIDTH];
            if (upd_taken_i) begin
               if (m_ctr[upd_hi] != 2'b11) m_ctr[upd_hi] = m_ctr[upd_hi] + 2'd1;
               m_valid[upd_bi] = 1'b1;
               m_tag[upd_bi]   = upd_pc_i[EADDR_WIDTH-1 -: BTB_TAG_WIDTH];
               m_tgt[upd_bi]   = upd_target_i;
            end else if (m_ctr[upd_hi] != 2'b00) begin
               m_ctr[upd_hi] = m_ctr[upd_hi] - 2'd1;
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- bp_fe_predict_top.sv
// branch prediction front end top
`timescale 1ns/1ns
`default_nettype none

module bp_fe_predict_top
   import bp_fe_pkg::*;
(
   input  wire                                    clk_i,
   input  wire                                    rst_n_i,

   // fetch stream
   input  wire                                    fetch_ready_i,
   output logic                                   fetch_v_o,
   output logic [EADDR_WIDTH-1:0]                 fetch_pc_o,
   output logic                                   fetch_predict_o,
   output logic [EADDR_WIDTH-1:0]                 fetch_target_o,
   output logic [BRANCH_METADATA_FWD_WIDTH-1:0]   fetch_metadata_o,

   // redirect from the back end
   input  wire                                    redir_v_i,
   input  wire [EADDR_WIDTH-1:0]                  redir_pc_i,

   // resolved branch training
   input  wire                                    upd_v_i,
   input  wire                                    upd_taken_i,
   input  wire [EADDR_WIDTH-1:0]                  upd_pc_i,
   input  wire [EADDR_WIDTH-1:0]                  upd_target_i,
   input  wire [BRANCH_METADATA_FWD_WIDTH-1:0]    upd_metadata_i
);

   logic                                 lookup_v;
   logic [EADDR_WIDTH-1:0]               lookup_pc;
   logic                                 bp_predict;
   logic [EADDR_WIDTH-1:0]               bp_target;
   logic [BRANCH_METADATA_FWD_WIDTH-1:0] bp_metadata;

   bp_fe_pc_gen u_pc_gen (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .fetch_ready_i    (fetch_ready_i),
      .redir_v_i        (redir_v_i),
      .redir_pc_i       (redir_pc_i),
      .predict_i        (bp_predict),
      .target_i         (bp_target),
      .metadata_i       (bp_metadata),
      .lookup_v_o       (lookup_v),
      .lookup_pc_o      (lookup_pc),
      .fetch_v_o        (fetch_v_o),
      .fetch_pc_o       (fetch_pc_o),
      .fetch_predict_o  (fetch_predict_o),
      .fetch_target_o   (fetch_target_o),
      .fetch_metadata_o (fetch_metadata_o)
   );

   bp_fe_branch_predictor u_predictor (
      .clk_i                 (clk_i),
      .rst_n_i               (rst_n_i),
      .r_v_i                 (lookup_v),
      .w_v_i                 (upd_v_i),
      .taken_i               (upd_taken_i),
      .pc_queue_i            (lookup_pc),
      .pc_cmd_i              (upd_target_i),
      .pc_branch_i           (upd_pc_i),
      .branch_metadata_fwd_i (upd_metadata_i),
      .predict_o             (bp_predict),
      .pc_o                  (bp_target),
      .branch_metadata_fwd_o (bp_metadata)
   );

endmodule

`default_nettype wire

//--- bp_fe_pc_gen.sv
// fetch address generator
`timescale 1ns/1ns
`default_nettype none

module bp_fe_pc_gen
   import bp_fe_pkg::*;
(
   input  wire                                    clk_i,
   input  wire                                    rst_n_i,

   input  wire                                    fetch_ready_i,
   input  wire                                    redir_v_i,
   input  wire [EADDR_WIDTH-1:0]                  redir_pc_i,

   // prediction for the address in s1
   input  wire                                    predict_i,
   input  wire [EADDR_WIDTH-1:0]                  target_i,
   input  wire [BRANCH_METADATA_FWD_WIDTH-1:0]    metadata_i,

   output logic                                   lookup_v_o,
   output logic [EADDR_WIDTH-1:0]                 lookup_pc_o,

   output logic                                   fetch_v_o,
   output logic [EADDR_WIDTH-1:0]                 fetch_pc_o,
   output logic                                   fetch_predict_o,
   output logic [EADDR_WIDTH-1:0]                 fetch_target_o,
   output logic [BRANCH_METADATA_FWD_WIDTH-1:0]   fetch_metadata_o
);

   logic [EADDR_WIDTH-1:0] s0_pc_q;    // address under lookup
   logic [EADDR_WIDTH-1:0] s1_pc_q;    // address with prediction ready
   logic                   s1_v_q;
   logic                   lookup_v;
   logic                   squash;

   // s0 always holds an address, so it only waits on ready and redirect
   assign lookup_v = fetch_ready_i && !redir_v_i;
   // s1 leaves with a taken prediction, the sequential s0 is wrong
   assign squash   = s1_v_q && fetch_ready_i && predict_i;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         s0_pc_q <= RESET_PC;
      end else if (redir_v_i) begin
         s0_pc_q <= redir_pc_i;
      end else if (lookup_v) begin
         if (squash) begin
            s0_pc_q <= target_i;                   // follow the predicted branch
         end else begin
            s0_pc_q <= s0_pc_q + INSTR_BYTES;
         end
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         s1_v_q <= 1'b0;
      end else if (redir_v_i) begin
         s1_v_q <= 1'b0;                           // flush
      end else if (lookup_v) begin
         s1_v_q <= !squash;
      end
   end

   always_ff @(posedge clk_i) begin
      if (lookup_v) begin
         s1_pc_q <= s0_pc_q;
      end
   end

   assign lookup_v_o       = lookup_v;
   assign lookup_pc_o      = s0_pc_q;
   assign fetch_v_o        = s1_v_q;
   assign fetch_pc_o       = s1_pc_q;
   assign fetch_predict_o  = predict_i;
   assign fetch_target_o   = target_i;
   assign fetch_metadata_o = metadata_i;

endmodule

`default_nettype wire

//--- bp_fe_branch_predictor.sv
// BTB and BHT branch predictor
`timescale 1ns/1ns
`default_nettype none

module bp_fe_branch_predictor
   import bp_fe_pkg::*;
(
   input  wire                                    clk_i,
   input  wire                                    rst_n_i,

   input  wire                                    r_v_i,
   input  wire                                    w_v_i,
   input  wire                                    taken_i,
   input  wire [EADDR_WIDTH-1:0]                  pc_queue_i,   // lookup address
   input  wire [EADDR_WIDTH-1:0]                  pc_cmd_i,     // resolved target
   input  wire [EADDR_WIDTH-1:0]                  pc_branch_i,  // address of the branch
   input  wire [BRANCH_METADATA_FWD_WIDTH-1:0]    branch_metadata_fwd_i,

   output logic                                   predict_o,
   output logic [EADDR_WIDTH-1:0]                 pc_o,
   output logic [BRANCH_METADATA_FWD_WIDTH-1:0]   branch_metadata_fwd_o
);

   logic [BTB_IDX_WIDTH-1:0]             btb_idx_w;
   logic [BHT_IDX_WIDTH-1:0]             bht_idx_w;
   logic                                 btb_w_v;
   logic                                 btb_hit;
   logic                                 bht_taken;
   logic [BRANCH_METADATA_FWD_WIDTH-1:0] meta_q;

   // update indices come back in the metadata
   assign btb_idx_w = branch_metadata_fwd_i[META_BTB_LSB +: BTB_IDX_WIDTH];
   assign bht_idx_w = branch_metadata_fwd_i[META_BHT_LSB +: BHT_IDX_WIDTH];
   assign btb_w_v   = w_v_i && taken_i;      // only taken branches allocate

   // metadata follows the table reads by one cycle
   always_ff @(posedge clk_i) begin
      if (r_v_i) begin
         meta_q <= {btb_idx_of(pc_queue_i), bht_idx_of(pc_queue_i), {RAS_ADDR_WIDTH{1'b0}}};
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // tables
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   bp_fe_btb u_btb (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .r_v_i           (r_v_i),
      .w_v_i           (btb_w_v),
      .idx_r_i         (btb_idx_of(pc_queue_i)),
      .idx_w_i         (btb_idx_w),
      .tag_r_i         (btb_tag_of(pc_queue_i)),
      .tag_w_i         (btb_tag_of(pc_branch_i)),
      .branch_target_i (pc_cmd_i),
      .branch_target_o (pc_o),
      .hit_o           (btb_hit)
   );

   bp_fe_bht u_bht (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .r_v_i     (r_v_i),
      .w_v_i     (w_v_i),
      .taken_i   (taken_i),
      .idx_r_i   (bht_idx_of(pc_queue_i)),
      .idx_w_i   (bht_idx_w),
      .predict_o (bht_taken)
   );

   // taken needs a target, so a BTB miss always falls through
   assign predict_o             = btb_hit && bht_taken;
   assign branch_metadata_fwd_o = meta_q;

endmodule

`default_nettype wire

//--- bp_fe_bht.sv
// branch history table
`timescale 1ns/1ns
`default_nettype none

module bp_fe_bht
   import bp_fe_pkg::*;
(
   input  wire                      clk_i,
   input  wire                      rst_n_i,

   input  wire                      r_v_i,
   input  wire                      w_v_i,
   input  wire                      taken_i,
   input  wire [BHT_IDX_WIDTH-1:0]  idx_r_i,
   input  wire [BHT_IDX_WIDTH-1:0]  idx_w_i,

   output logic                     predict_o
);

   logic [BHT_CTR_WIDTH-1:0] ctr_mem [BHT_ENTRIES];
   logic [BHT_CTR_WIDTH-1:0] ctr_cur;
   logic [BHT_CTR_WIDTH-1:0] ctr_nxt;
   logic                     predict_q;

   assign ctr_cur = ctr_mem[idx_w_i];

   // saturating step toward the resolved direction
   always_comb begin
      ctr_nxt = ctr_cur;
      if (taken_i) begin
         if (ctr_cur != BHT_CTR_MAX) begin
            ctr_nxt = ctr_cur + 2'd1;
         end
      end else begin
         if (ctr_cur != '0) begin
            ctr_nxt = ctr_cur - 2'd1;
         end
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // counter array
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < BHT_ENTRIES; i++) begin
            ctr_mem[i] <= BHT_CTR_INIT;
         end
      end else if (w_v_i) begin
         ctr_mem[idx_w_i] <= ctr_nxt;
      end
   end

   // registered read, upper bit is the direction
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         predict_q <= 1'b0;
      end else if (r_v_i) begin
         predict_q <= ctr_mem[idx_r_i][BHT_CTR_WIDTH-1];   // pre-update value
      end
   end

   assign predict_o = predict_q;

endmodule

`default_nettype wire

//--- bp_fe_btb.sv
// branch target buffer
`timescale 1ns/1ns
`default_nettype none

module bp_fe_btb
   import bp_fe_pkg::*;
(
   input  wire                      clk_i,
   input  wire                      rst_n_i,

   input  wire                      r_v_i,
   input  wire                      w_v_i,
   input  wire [BTB_IDX_WIDTH-1:0]  idx_r_i,
   input  wire [BTB_IDX_WIDTH-1:0]  idx_w_i,
   input  wire [BTB_TAG_WIDTH-1:0]  tag_r_i,
   input  wire [BTB_TAG_WIDTH-1:0]  tag_w_i,
   input  wire [EADDR_WIDTH-1:0]    branch_target_i,

   output logic [EADDR_WIDTH-1:0]   branch_target_o,
   output logic                     hit_o
);

   // direct-mapped storage
   logic [BTB_TAG_WIDTH-1:0] tag_mem [BTB_ENTRIES];
   logic [EADDR_WIDTH-1:0]   tgt_mem [BTB_ENTRIES];
   logic [BTB_ENTRIES-1:0]   valid_q;

   logic                     hit_q;
   logic [EADDR_WIDTH-1:0]   target_q;
   logic                     tag_match;

   // valid entry whose tag equals the lookup tag
   assign tag_match = valid_q[idx_r_i] && (tag_mem[idx_r_i] == tag_r_i);

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // write side
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         valid_q <= '0;                  // all entries empty
      end else if (w_v_i) begin
         valid_q[idx_w_i] <= 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (w_v_i) begin
         tag_mem[idx_w_i] <= tag_w_i;
         tgt_mem[idx_w_i] <= branch_target_i;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // read side
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // same-cycle write is not visible here, the read gets the old entry
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         hit_q <= 1'b0;
      end else if (r_v_i) begin
         hit_q <= tag_match;
      end
   end

   always_ff @(posedge clk_i) begin
      if (r_v_i) begin
         target_q <= tgt_mem[idx_r_i];   // held until next read
      end
   end

   assign hit_o           = hit_q;
   assign branch_target_o = target_q;

endmodule

`default_nettype wire

//--- bp_fe_pkg.sv
// branch prediction front end definitions
`default_nettype none

package bp_fe_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // address and table geometry
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   localparam int EADDR_WIDTH    = 32;
   localparam int BYTE_OFF_WIDTH = 2;    // word aligned instructions
   localparam int BTB_IDX_WIDTH  = 6;    // 64 entries
   localparam int BHT_IDX_WIDTH  = 8;    // 256 counters
   localparam int RAS_ADDR_WIDTH = 4;    // carried as zero
   localparam int BTB_TAG_WIDTH  = EADDR_WIDTH - BTB_IDX_WIDTH - BYTE_OFF_WIDTH;

   localparam int BTB_ENTRIES = 1 << BTB_IDX_WIDTH;
   localparam int BHT_ENTRIES = 1 << BHT_IDX_WIDTH;

   // forward metadata is {btb index, bht index, ras field}
   localparam int BRANCH_METADATA_FWD_WIDTH = BTB_IDX_WIDTH + BHT_IDX_WIDTH + RAS_ADDR_WIDTH;
   localparam int META_BHT_LSB = RAS_ADDR_WIDTH;
   localparam int META_BTB_LSB = RAS_ADDR_WIDTH + BHT_IDX_WIDTH;

   // two-bit saturating counters
   localparam int BHT_CTR_WIDTH = 2;
   localparam logic [BHT_CTR_WIDTH-1:0] BHT_CTR_INIT = 2'b01;   // weakly not taken
   localparam logic [BHT_CTR_WIDTH-1:0] BHT_CTR_MAX  = 2'b11;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // fetch addressing
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   localparam logic [EADDR_WIDTH-1:0] RESET_PC    = 32'h0000_1000;
   localparam logic [EADDR_WIDTH-1:0] INSTR_BYTES = 32'd4;

   // both table indices start right above the byte offset
   function automatic logic [BTB_IDX_WIDTH-1:0] btb_idx_of(input logic [EADDR_WIDTH-1:0] pc);
      return pc[BYTE_OFF_WIDTH +: BTB_IDX_WIDTH];
   endfunction

   function automatic logic [BTB_TAG_WIDTH-1:0] btb_tag_of(input logic [EADDR_WIDTH-1:0] pc);
      return pc[EADDR_WIDTH-1 -: BTB_TAG_WIDTH];
   endfunction

   function automatic logic [BHT_IDX_WIDTH-1:0] bht_idx_of(input logic [EADDR_WIDTH-1:0] pc);
      return pc[BYTE_OFF_WIDTH +: BHT_IDX_WIDTH];
   endfunction

endpackage

`default_nettype wire
